// File: replay_table.f
source/rtab_pkg.sv
source/rtab_state_if.sv
source/rtab_entry_store.sv
source/rtab_dep_tracker.sv
source/rtab_pop_sched.sv
source/replay_table.sv
verif/tb_replay_table.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_replay_table \
    -f replay_table.f -o tb_replay_table

out=$(./obj_dir/tb_replay_table)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: source/replay_table.sv
`timescale 1ns/1ps
/*
 * Replay table top level
 * Parks cache requests in per-line lists and replays them
 * once their dependencies clear
 */
module replay_table
    import rtab_pkg::*;
#(
    parameter  int num_entries = 8,
    localparam int ptr_w       = $clog2(num_entries)
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    // Status
    output logic             empty_o,
    output logic             full_o,
    // Line check
    input  logic             check_i,
    input  nline_t           check_nline_i,
    output logic             check_hit_o,
    // Allocation
    input  logic             alloc_i,
    input  logic             alloc_link_i,
    input  rtab_req_t        alloc_req_i,
    input  rtab_deps_t       alloc_deps_i,
    // Pop with valid/ready, then commit or rollback
    output logic             pop_valid_o,
    input  logic             pop_ready_i,
    output rtab_req_t        pop_req_o,
    output logic [ptr_w-1:0] pop_ptr_o,
    input  logic             pop_commit_i,
    input  logic             pop_rback_i,
    input  logic [ptr_w-1:0] pop_ptr_i,
    // Wake-up events
    input  logic             refill_i,
    input  nline_t           refill_nline_i,
    input  logic             miss_ready_i
);

    logic [num_entries-1:0] alloc_bv;
    logic [num_entries-1:0] ready_deps;

    rtab_state_if #(.num_entries(num_entries)) state_if ();
    rtab_pop_if   #(.num_entries(num_entries)) pop_if ();

    rtab_entry_store #(.num_entries(num_entries)) i_entry_store (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_i       (check_i),
        .check_nline_i (check_nline_i),
        .check_hit_o   (check_hit_o),
        .alloc_i       (alloc_i),
        .alloc_link_i  (alloc_link_i),
        .alloc_req_i   (alloc_req_i),
        .alloc_bv_o    (alloc_bv),
        .empty_o       (empty_o),
        .full_o        (full_o),
        .st            (state_if.store),
        .pop           (pop_if.store)
    );

    rtab_dep_tracker #(.num_entries(num_entries)) i_dep_tracker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alloc_bv_i     (alloc_bv),
        .alloc_deps_i   (alloc_deps_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .miss_ready_i   (miss_ready_i),
        .ready_deps_o   (ready_deps),
        .st             (state_if.deps),
        .pop            (pop_if.deps)
    );

    rtab_pop_sched #(.num_entries(num_entries)) i_pop_sched (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ready_deps_i (ready_deps),
        .pop_valid_o  (pop_valid_o),
        .pop_ready_i  (pop_ready_i),
        .pop_req_o    (pop_req_o),
        .pop_ptr_o    (pop_ptr_o),
        .pop_commit_i (pop_commit_i),
        .pop_rback_i  (pop_rback_i),
        .pop_ptr_i    (pop_ptr_i),
        .st           (state_if.sched),
        .pop          (pop_if.sched)
    );

endmodule

// File: source/rtab_dep_tracker.sv
`timescale 1ns/1ps
/*
 * Replay table dependency tracker
 * Per-entry wait bits, loaded on allocation or rollback
 * and cleared by refill and miss handler events
 */
module rtab_dep_tracker
    import rtab_pkg::*;
#(
    parameter int num_entries = 8
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [num_entries-1:0] alloc_bv_i,
    input  rtab_deps_t             alloc_deps_i,
    input  logic                   refill_i,
    input  nline_t                 refill_nline_i,
    input  logic                   miss_ready_i,
    output logic [num_entries-1:0] ready_deps_o,
    rtab_state_if.deps             st,
    rtab_pop_if.deps               pop
);

    rtab_deps_t [num_entries-1:0] deps_q;
    logic [num_entries-1:0]       load_bv;
    logic [num_entries-1:0]       match_nline;
    logic [num_entries-1:0]       match_set;

    // Both allocation and rollback take the dependencies on the alloc port
    assign load_bv = alloc_bv_i | pop.rback_bv;

    for (genvar i = 0; i < num_entries; i++) begin : gen_match
        assign match_nline[i]  = refill_i & (st.nline[i] == refill_nline_i);
        assign match_set[i]    = refill_i &
                                 (st.nline[i][SET_W-1:0] == refill_nline_i[SET_W-1:0]);
        // Free entries never report ready
        assign ready_deps_o[i] = st.valid_bv[i] & ~|deps_q[i];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : deps_ff
        if (!rst_ni) begin
            deps_q <= '0;
        end else begin
            for (int i = 0; i < num_entries; i++) begin
                if (load_bv[i]) begin
                    deps_q[i] <= alloc_deps_i;
                end else begin
                    // Refill of the same line ends the outstanding miss
                    if (match_nline[i]) begin
                        deps_q[i].mshr_hit <= 1'b0;
                    end
                    // Any refill in the set frees the directory
                    if (match_set[i]) begin
                        deps_q[i].dir_busy <= 1'b0;
                    end
                    if (miss_ready_i) begin
                        deps_q[i].mshr_full <= 1'b0;
                    end
                end
            end
        end
    end

    // Store only allocates free entries, rollback only targets valid ones
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_bv_i & pop.rback_bv) == '0)
        else $error("rtab: allocation and rollback on the same entry");

endmodule

// File: source/rtab_entry_store.sv
`timescale 1ns/1ps
/*
 * Replay table entry store
 * Holds parked requests with valid, head and tail flags and next pointers,
 * answers nline checks and places new entries in the lowest free slot
 */
module rtab_entry_store
    import rtab_pkg::*;
#(
    parameter  int num_entries = 8,
    localparam int ptr_w       = $clog2(num_entries)
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   check_i,
    input  nline_t                 check_nline_i,
    output logic                   check_hit_o,
    input  logic                   alloc_i,
    input  logic                   alloc_link_i,
    input  rtab_req_t              alloc_req_i,
    output logic [num_entries-1:0] alloc_bv_o,
    output logic                   empty_o,
    output logic                   full_o,
    rtab_state_if.store            st,
    rtab_pop_if.store              pop
);

    rtab_req_t [num_entries-1:0]       req_q;
    logic [num_entries-1:0][ptr_w-1:0] next_q;
    logic [num_entries-1:0]            valid_q;
    logic [num_entries-1:0]            head_q;
    logic [num_entries-1:0]            tail_q;

    logic [num_entries-1:0]            free_1hot;
    logic [ptr_w-1:0]                  free_ptr;
    logic [num_entries-1:0]            check_hit_bv;
    logic [num_entries-1:0]            match_tail_bv;
    logic [num_entries-1:0]            head_set;
    logic [num_entries-1:0]            head_clr;
    logic                              alloc;

    // Lowest free entry, scanned from the top so the smallest index wins
    always_comb begin : free_pick
        free_1hot = '0;
        free_ptr  = '0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_1hot    = '0;
                free_1hot[i] = 1'b1;
                free_ptr     = ptr_w'(i);
            end
        end
    end

    assign alloc      = alloc_i | alloc_link_i;
    assign alloc_bv_o = free_1hot & {num_entries{alloc}};

    // Line index of every stored request
    for (genvar i = 0; i < num_entries; i++) begin : gen_nline
        assign st.nline[i]     = addr_to_nline(req_q[i].addr);
        assign check_hit_bv[i] = valid_q[i] & (st.nline[i] == check_nline_i);
    end

    // Check answer is purely combinational
    assign check_hit_o   = |check_hit_bv;
    // Tail of the list the new entry gets linked behind
    assign match_tail_bv = check_hit_bv & tail_q;

    // New list head only on a plain allocation
    assign head_set = (alloc_bv_o & {num_entries{alloc_i}}) | pop.rback_bv;
    // A taken head stops competing, a linked entry never starts as head
    assign head_clr = pop.take_bv | (alloc_bv_o & {num_entries{alloc_link_i}});

    always_ff @(posedge clk_i or negedge rst_ni) begin : flags_ff
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_bv_o) & ~pop.commit_bv;
            head_q  <= (head_q & ~head_clr) | head_set;
            // New entry is always the tail, the old tail hands it over
            tail_q  <= (tail_q & ~(match_tail_bv & {num_entries{alloc_link_i}})) | alloc_bv_o;
        end
    end

    // Request payload and list links
    always_ff @(posedge clk_i) begin : payload_ff
        for (int i = 0; i < num_entries; i++) begin
            // Rollback refreshes the request in place
            if (alloc_bv_o[i] || pop.rback_bv[i]) begin
                req_q[i] <= alloc_req_i;
            end
            if (alloc_link_i && match_tail_bv[i]) begin
                next_q[i] <= free_ptr;
            end
        end
    end

    assign st.valid_bv = valid_q;
    assign st.head_bv  = head_q;
    assign st.tail_bv  = tail_q;
    assign st.next_ptr = next_q;
    assign st.req      = req_q;

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    // Only one list per line, so only one tail can match
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_i |-> $onehot0(match_tail_bv))
        else $error("rtab: several tails match the checked nline");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc |-> !full_o)
        else $error("rtab: allocation while full");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> (check_i && check_hit_o && !alloc_i))
        else $error("rtab: link allocation without check hit");

endmodule

// File: source/rtab_pkg.sv
/*
 * Replay table package
 * Address widths, stored request layout, dependency bits
 * and the pop scheduler states
 */
package rtab_pkg;

    // Request address and cache-line geometry
    localparam int ADDR_W        = 32;
    localparam int LINE_OFFSET_W = 6;
    localparam int NLINE_W       = ADDR_W - LINE_OFFSET_W;
    // Set index sits in the low bits of the nline
    localparam int SET_W         = 7;

    typedef logic [NLINE_W-1:0] nline_t;

    // Opcode travels with the request, the table never decodes it
    typedef enum logic [1:0] {
        OP_LOAD     = 2'd0,
        OP_STORE    = 2'd1,
        OP_PREFETCH = 2'd2,
        OP_AMO      = 2'd3
    } rtab_op_e;

    // Parked request, 42 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        rtab_op_e          op;
        logic [7:0]        tag;
    } rtab_req_t;

    // Reasons an entry cannot be replayed yet
    typedef struct packed {
        // Miss to the same line still outstanding
        logic mshr_hit;
        // Miss handler has no free slot
        logic mshr_full;
        // Set is being refilled
        logic dir_busy;
    } rtab_deps_t;

    // Pop scheduler states
    typedef enum logic [1:0] {
        POP_HEAD      = 2'd0,
        POP_NEXT      = 2'd1,
        POP_NEXT_WAIT = 2'd2
    } pop_state_e;

    // Cache-line index of a request address
    function automatic nline_t addr_to_nline(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:LINE_OFFSET_W];
    endfunction

endpackage

// File: source/rtab_pop_sched.sv
`timescale 1ns/1ps
/*
 * Replay table pop scheduler
 * Round-robin pick among ready list heads, then walks the list
 * to its tail, and turns commit and rollback into event vectors
 */
module rtab_pop_sched
    import rtab_pkg::*;
#(
    parameter  int num_entries = 8,
    localparam int ptr_w       = $clog2(num_entries)
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [num_entries-1:0] ready_deps_i,
    output logic                   pop_valid_o,
    input  logic                   pop_ready_i,
    output rtab_req_t              pop_req_o,
    output logic [ptr_w-1:0]       pop_ptr_o,
    input  logic                   pop_commit_i,
    input  logic                   pop_rback_i,
    input  logic [ptr_w-1:0]       pop_ptr_i,
    rtab_state_if.sched            st,
    rtab_pop_if.sched              pop
);

    pop_state_e             state_q, state_d;
    logic [ptr_w-1:0]       cur_q, cur_d;
    logic [ptr_w-1:0]       rr_q;
    logic                   hold_q;
    logic [num_entries-1:0] hold_bv_q;

    logic [num_entries-1:0] head_ready;
    logic [num_entries-1:0] rr_bv;
    logic [num_entries-1:0] sel_bv;
    logic                   sel_tail;
    logic                   head_take;
    logic                   xfer;

    function automatic logic [num_entries-1:0] to_bv(input logic [ptr_w-1:0] ptr);
        logic [num_entries-1:0] bv;
        bv = '0;
        for (int i = 0; i < num_entries; i++) begin
            bv[i] = (ptr_w'(i) == ptr);
        end
        return bv;
    endfunction

    function automatic logic [ptr_w-1:0] to_ptr(input logic [num_entries-1:0] bv);
        logic [ptr_w-1:0] ptr;
        ptr = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (bv[i]) ptr = ptr_w'(i);
        end
        return ptr;
    endfunction

    assign head_ready = st.valid_bv & st.head_bv & ready_deps_i;

    // First ready head at or after the round-robin pointer
    always_comb begin : rr_pick
        int  idx;
        logic found;
        rr_bv = '0;
        found = 1'b0;
        for (int k = 0; k < num_entries; k++) begin
            idx = (int'(rr_q) + k) % num_entries;
            if (!found && head_ready[idx]) begin
                found      = 1'b1;
                rr_bv[idx] = 1'b1;
            end
        end
    end

    // Stalled head offer stays fixed until taken
    assign sel_bv      = (state_q != POP_HEAD) ? to_bv(cur_q) :
                         hold_q ? hold_bv_q : rr_bv;
    assign pop_valid_o = (state_q == POP_HEAD) ? |head_ready : 1'b1;
    assign pop_ptr_o   = to_ptr(sel_bv);
    assign pop_req_o   = st.req[pop_ptr_o];
    assign sel_tail    = |(sel_bv & st.tail_bv);
    assign xfer        = pop_valid_o & pop_ready_i;

    always_comb begin : walk_fsm
        state_d   = state_q;
        cur_d     = cur_q;
        head_take = 1'b0;
        unique case (state_q)
            POP_HEAD: begin
                // Rollback of a popped tail may land here
                if (!pop_rback_i && xfer) begin
                    head_take = 1'b1;
                    if (!sel_tail) begin
                        state_d = POP_NEXT;
                        cur_d   = st.next_ptr[pop_ptr_o];
                    end
                end
            end
            POP_NEXT, POP_NEXT_WAIT: begin
                if (pop_rback_i) begin
                    state_d = POP_HEAD;
                end else if (pop_ready_i) begin
                    if (!sel_tail) begin
                        state_d = POP_NEXT;
                        cur_d   = st.next_ptr[pop_ptr_o];
                    end else begin
                        state_d = POP_HEAD;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            default: state_d = POP_HEAD;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : sched_ff
        if (!rst_ni) begin
            state_q   <= POP_HEAD;
            cur_q     <= '0;
            rr_q      <= '0;
            hold_q    <= 1'b0;
            hold_bv_q <= '0;
        end else begin
            state_q   <= state_d;
            cur_q     <= cur_d;
            hold_q    <= (state_q == POP_HEAD) & pop_valid_o & ~pop_ready_i;
            hold_bv_q <= sel_bv;
            // Priority moves past the head just taken
            if (head_take) begin
                rr_q <= (int'(pop_ptr_o) == num_entries - 1) ? '0 : pop_ptr_o + 1'b1;
            end
        end
    end

    assign pop.take_bv   = sel_bv & {num_entries{xfer}};
    assign pop.commit_bv = to_bv(pop_ptr_i) & {num_entries{pop_commit_i}};
    assign pop.rback_bv  = to_bv(pop_ptr_i) & {num_entries{pop_rback_i}};

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        xfer |=> (pop_commit_i || pop_rback_i))
        else $error("rtab: transfer without commit or rollback");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !pop_ready_i)
        else $error("rtab: pop accepted during rollback");

    // Entry stays valid from take until its commit
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pop_commit_i || pop_rback_i) |-> st.valid_bv[pop_ptr_i])
        else $error("rtab: commit or rollback of an invalid entry");

endmodule

// File: source/rtab_state_if.sv
`timescale 1ns/1ps
/*
 * Replay table internal interfaces
 * Entry state from the store, pop events from the scheduler
 */
interface rtab_state_if
    import rtab_pkg::*;
#(
    parameter int num_entries = 8
);
    localparam int ptr_w = $clog2(num_entries);

    // Per-entry list flags
    logic [num_entries-1:0]            valid_bv;
    logic [num_entries-1:0]            head_bv;
    logic [num_entries-1:0]            tail_bv;
    // Successor of each entry in its list
    logic [num_entries-1:0][ptr_w-1:0] next_ptr;
    rtab_req_t [num_entries-1:0]       req;
    // Line index of each stored address
    nline_t [num_entries-1:0]          nline;

    modport store (output valid_bv, head_bv, tail_bv, next_ptr, req, nline);
    modport sched (input valid_bv, head_bv, tail_bv, next_ptr, req);
    modport deps  (input valid_bv, nline);
endinterface

interface rtab_pop_if #(
    parameter int num_entries = 8
);
    // One-hot event vectors, at most one bit set each
    logic [num_entries-1:0] take_bv;
    logic [num_entries-1:0] commit_bv;
    logic [num_entries-1:0] rback_bv;

    modport sched (output take_bv, commit_bv, rback_bv);
    modport store (input take_bv, commit_bv, rback_bv);
    modport deps  (input rback_bv);
endinterface

// File: verif/tb_replay_table.sv
`timescale 1ns/1ps
/*
 * Replay table testbench
 * Directed tests for line check, list order, wake-up, rollback and full
 */
module tb_replay_table
    import rtab_pkg::*;
();

    localparam int num_entries  = 8;
    localparam int ptr_w        = $clog2(num_entries);
    localparam int reset_cycles = 16;
    // Longest wait for an offer while pop_ready_i is high
    localparam int pop_wait     = 20;
    // Cycle budgets of reset and the five tests
    localparam int timeout_cycles = 2 * (20 + 30 + 30 + 40 + 40 + 60);

    logic             clk_i;
    logic             rst_ni;
    logic             empty_o;
    logic             full_o;
    logic             check_i;
    nline_t           check_nline_i;
    logic             check_hit_o;
    logic             alloc_i;
    logic             alloc_link_i;
    rtab_req_t        alloc_req_i;
    rtab_deps_t       alloc_deps_i;
    logic             pop_valid_o;
    logic             pop_ready_i;
    rtab_req_t        pop_req_o;
    logic [ptr_w-1:0] pop_ptr_o;
    logic             pop_commit_i;
    logic             pop_rback_i;
    logic [ptr_w-1:0] pop_ptr_i;
    logic             refill_i;
    nline_t           refill_nline_i;
    logic             miss_ready_i;

    integer seed;
    int     error_count = 0;
    int     cycle_count;

    replay_table #(.num_entries(num_entries)) i_replay_table (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .empty_o        (empty_o),
        .full_o         (full_o),
        .check_i        (check_i),
        .check_nline_i  (check_nline_i),
        .check_hit_o    (check_hit_o),
        .alloc_i        (alloc_i),
        .alloc_link_i   (alloc_link_i),
        .alloc_req_i    (alloc_req_i),
        .alloc_deps_i   (alloc_deps_i),
        .pop_valid_o    (pop_valid_o),
        .pop_ready_i    (pop_ready_i),
        .pop_req_o      (pop_req_o),
        .pop_ptr_o      (pop_ptr_o),
        .pop_commit_i   (pop_commit_i),
        .pop_rback_i    (pop_rback_i),
        .pop_ptr_i      (pop_ptr_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .miss_ready_i   (miss_ready_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Line index is the address without its 64-byte offset
    function automatic nline_t line_of(input logic [ADDR_W-1:0] addr);
        return nline_t'(addr >> LINE_OFFSET_W);
    endfunction

    function automatic rtab_req_t make_req(input logic [ADDR_W-1:0] addr,
                                           input rtab_op_e op, input logic [7:0] tag);
        rtab_req_t r;
        r.addr = addr;
        r.op   = op;
        r.tag  = tag;
        return r;
    endfunction

    function automatic rtab_deps_t deps_of(input logic hit, input logic full,
                                           input logic busy);
        rtab_deps_t d;
        d.mshr_hit  = hit;
        d.mshr_full = full;
        d.dir_busy  = busy;
        return d;
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_req(input string name, input rtab_req_t got, input rtab_req_t exp);
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_ptr(input string name, input logic [ptr_w-1:0] got,
                               input logic [ptr_w-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // One-cycle allocation, a linked one checks its line in the same cycle
    task automatic alloc_entry(input rtab_req_t req, input rtab_deps_t deps, input logic link);
        @(posedge clk_i);
        alloc_i       <= ~link;
        alloc_link_i  <= link;
        check_i       <= link;
        check_nline_i <= line_of(req.addr);
        alloc_req_i   <= req;
        alloc_deps_i  <= deps;
        @(negedge clk_i);
        if (link) begin
            compare_bit("check_hit_o", check_hit_o, 1'b1);
        end
        @(posedge clk_i);
        alloc_i      <= 1'b0;
        alloc_link_i <= 1'b0;
        check_i      <= 1'b0;
    endtask

    task automatic check_line(input nline_t nline, input logic exp);
        @(posedge clk_i);
        check_i       <= 1'b1;
        check_nline_i <= nline;
        @(negedge clk_i);
        compare_bit("check_hit_o", check_hit_o, exp);
        @(posedge clk_i);
        check_i <= 1'b0;
    endtask

    task automatic pulse_refill(input nline_t nline);
        @(posedge clk_i);
        refill_i       <= 1'b1;
        refill_nline_i <= nline;
        @(posedge clk_i);
        refill_i <= 1'b0;
    endtask

    task automatic pulse_miss_ready();
        @(posedge clk_i);
        miss_ready_i <= 1'b1;
        @(posedge clk_i);
        miss_ready_i <= 1'b0;
    endtask

    task automatic expect_no_pop(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            compare_bit("pop_valid_o", pop_valid_o, 1'b0);
        end
    endtask

    // Samples at falling edges until an offer shows up or the limit is hit
    task automatic wait_offer(input int max_cycles, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < max_cycles) begin
            @(negedge clk_i);
            seen = pop_valid_o;
            n++;
        end
    endtask

    // Takes the next offer, then commits it or rolls it back one cycle later
    task automatic pop_entry(input logic rback, input rtab_req_t new_req,
                             input rtab_deps_t new_deps, output rtab_req_t req,
                             output logic [ptr_w-1:0] ptr);
        logic seen;
        @(posedge clk_i);
        pop_ready_i <= 1'b1;
        wait_offer(pop_wait, seen);
        req = pop_req_o;
        ptr = pop_ptr_o;
        @(posedge clk_i);
        pop_ready_i <= 1'b0;
        if (!seen) begin
            error_count++;
            $display("pop_valid_o never rose while pop_ready_i was high");
        end else begin
            pop_ptr_i <= ptr;
            if (rback) begin
                pop_rback_i  <= 1'b1;
                alloc_req_i  <= new_req;
                alloc_deps_i <= new_deps;
            end else begin
                pop_commit_i <= 1'b1;
            end
            @(posedge clk_i);
            pop_commit_i <= 1'b0;
            pop_rback_i  <= 1'b0;
        end
    endtask

    task automatic reset_and_check_test();
        logic [ADDR_W-1:0] addr;
        rtab_req_t         req;
        rtab_req_t         got;
        logic [ptr_w-1:0]  ptr;
        addr = $random(seed);
        req  = make_req(addr, OP_LOAD, 8'h11);
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b1);
        compare_bit("full_o", full_o, 1'b0);
        compare_bit("pop_valid_o", pop_valid_o, 1'b0);
        alloc_entry(req, deps_of(1'b1, 1'b0, 1'b0), 1'b0);
        check_line(line_of(addr), 1'b1);
        check_line(line_of(addr) ^ nline_t'(1), 1'b0);
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b0);
        compare_bit("pop_valid_o", pop_valid_o, 1'b0);
        // Miss ends, then drain
        pulse_refill(line_of(addr));
        pop_entry(1'b0, req, '0, got, ptr);
        compare_req("pop_req_o", got, req);
        // An empty table fills entry 0 first
        compare_ptr("pop_ptr_o", ptr, ptr_w'(0));
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic list_order_test();
        logic [ADDR_W-1:0] base;
        rtab_req_t         exp_q[3];
        rtab_req_t         got;
        logic [ptr_w-1:0]  ptr;
        base = $random(seed);
        base[LINE_OFFSET_W-1:0] = '0;
        // Three requests inside one line
        exp_q[0] = make_req(base + 32'h04, OP_LOAD, 8'h21);
        exp_q[1] = make_req(base + 32'h10, OP_STORE, 8'h22);
        exp_q[2] = make_req(base + 32'h28, OP_LOAD, 8'h23);
        alloc_entry(exp_q[0], '0, 1'b0);
        alloc_entry(exp_q[1], '0, 1'b1);
        alloc_entry(exp_q[2], '0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            pop_entry(1'b0, exp_q[i], '0, got, ptr);
            compare_req("pop_req_o", got, exp_q[i]);
            // Allocations into the empty table took entries 0, 1 and 2
            compare_ptr("pop_ptr_o", ptr, ptr_w'(i));
        end
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic dep_wakeup_test();
        logic [ADDR_W-1:0] addr;
        rtab_req_t         req;
        rtab_req_t         got;
        logic [ptr_w-1:0]  ptr;
        logic              seen;
        addr = $random(seed);
        req  = make_req(addr, OP_PREFETCH, 8'h31);
        alloc_entry(req, deps_of(1'b1, 1'b0, 1'b0), 1'b0);
        expect_no_pop(10);
        // Refill of another line in the same set leaves the miss outstanding
        pulse_refill(line_of(addr) ^ (nline_t'(1) << SET_W));
        expect_no_pop(3);
        pulse_refill(line_of(addr));
        wait_offer(2, seen);
        compare_bit("pop_valid_o", seen, 1'b1);
        compare_req("pop_req_o", pop_req_o, req);
        pop_entry(1'b0, req, '0, got, ptr);
        compare_req("pop_req_o", got, req);
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic rollback_test();
        logic [ADDR_W-1:0] addr;
        rtab_req_t         req;
        rtab_req_t         new_req;
        rtab_req_t         got;
        logic [ptr_w-1:0]  ptr;
        logic [ptr_w-1:0]  ptr_again;
        logic              seen;
        addr    = $random(seed);
        req     = make_req(addr, OP_STORE, 8'h41);
        new_req = req;
        new_req.tag = 8'h42;
        alloc_entry(req, '0, 1'b0);
        pop_entry(1'b1, new_req, deps_of(1'b0, 1'b1, 1'b0), got, ptr);
        compare_req("pop_req_o", got, req);
        // Lone entry of an empty table sits in entry 0
        compare_ptr("pop_ptr_o", ptr, ptr_w'(0));
        // Waits on a full miss handler now
        expect_no_pop(5);
        pulse_miss_ready();
        wait_offer(2, seen);
        compare_bit("pop_valid_o", seen, 1'b1);
        compare_req("pop_req_o", pop_req_o, new_req);
        compare_ptr("pop_ptr_o", pop_ptr_o, ptr_w'(0));
        pop_entry(1'b0, new_req, '0, got, ptr_again);
        compare_req("pop_req_o", got, new_req);
        compare_ptr("pop_ptr_o", ptr_again, ptr_w'(0));
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b1);
    endtask

    task automatic full_test();
        logic [ADDR_W-1:0]      addr;
        rtab_req_t              exp_q[num_entries];
        logic [num_entries-1:0] taken;
        rtab_req_t              got;
        logic [ptr_w-1:0]       ptr;
        logic                   found;
        taken = '0;
        for (int i = 0; i < num_entries; i++) begin
            addr = $random(seed);
            // Low line bits differ, so every request has its own line
            addr[LINE_OFFSET_W +: 3] = 3'(i);
            exp_q[i] = make_req(addr, OP_LOAD, 8'h50 + 8'(i));
            alloc_entry(exp_q[i], '0, 1'b0);
        end
        @(negedge clk_i);
        compare_bit("full_o", full_o, 1'b1);
        compare_bit("empty_o", empty_o, 1'b0);
        for (int i = 0; i < num_entries; i++) begin
            pop_entry(1'b0, exp_q[0], '0, got, ptr);
            found = 1'b0;
            for (int j = 0; j < num_entries; j++) begin
                if (!found && !taken[j] && got === exp_q[j]) begin
                    taken[j] = 1'b1;
                    found    = 1'b1;
                    // Request j went into entry j of the empty table
                    compare_ptr("pop_ptr_o", ptr, ptr_w'(j));
                end
            end
            if (!found) begin
                error_count++;
                $display("popped request with tag %h was never allocated or came out twice",
                         got.tag);
            end
        end
        @(negedge clk_i);
        compare_bit("empty_o", empty_o, 1'b1);
        compare_bit("full_o", full_o, 1'b0);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("errors: %0d", error_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        seed = 32'h7bef;
        // Every DUT input starts in a known state
        rst_ni         <= 1'b0;
        check_i        <= 1'b0;
        check_nline_i  <= '0;
        alloc_i        <= 1'b0;
        alloc_link_i   <= 1'b0;
        alloc_req_i    <= '0;
        alloc_deps_i   <= '0;
        pop_ready_i    <= 1'b0;
        pop_commit_i   <= 1'b0;
        pop_rback_i    <= 1'b0;
        pop_ptr_i      <= '0;
        refill_i       <= 1'b0;
        refill_nline_i <= '0;
        miss_ready_i   <= 1'b0;
        repeat (reset_cycles) @(posedge clk_i);
        rst_ni <= 1'b1;

        reset_and_check_test();
        list_order_test();
        dep_wakeup_test();
        rollback_test();
        full_test();

        repeat (2) @(posedge clk_i);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
